/* rtl/tile_macros.svh */
`ifndef TILE_MACROS_SVH
`define TILE_MACROS_SVH

// tile geometry
`define TILE_SIZE 8
`define NUM_CH 4

// field widths
`define PIX_W 8
`define FLAG_W 3

// engine result widths
`define CALC_SIZE_W 7
`define COMP_SIZE_W 6

`endif

/* rtl/tile_pkg.sv */
`include "tile_macros.svh"

package tile_pkg;

	// one channel of pixels or absolute values
	typedef logic [`PIX_W*`TILE_SIZE*`TILE_SIZE-1:0] tile_data_t;

	// one flag plane
	typedef logic [`FLAG_W*`TILE_SIZE*`TILE_SIZE-1:0] tile_flag_t;

	typedef logic [`CALC_SIZE_W-1:0] calc_size_t;
	typedef logic [`COMP_SIZE_W-1:0] comp_size_t;

	// also the processing order
	typedef enum logic [1:0] {CH_B, CH_G, CH_R, CH_A} channel_e;

	typedef enum logic {ORIENT_COL, ORIENT_ROW} orient_e;

endpackage

/* rtl/ctrl_pkg.sv */
package ctrl_pkg;

	// stages in order, engine stages are consecutive
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_GENERATE,
		ST_CALCULATE,
		ST_COMPRESS,
		ST_DONE
	} stage_e;

	// calculate order
	typedef enum logic [1:0] {
		SLOT_A_ROW,
		SLOT_A_COL,
		SLOT_B_ROW,
		SLOT_B_COL
	} calc_slot_e;

endpackage

/* rtl/stage_if.sv */
`timescale 1ns/1ps

interface stage_if;

	ctrl_pkg::stage_e stage;
	logic [1:0] slot;

	// request accepted by the engine
	logic issue;

	// response arrives this cycle
	logic capture;

	modport seq
	(
		output stage, slot, issue, capture
	);

	modport unit
	(
		input stage, slot, issue, capture
	);

endinterface

/* rtl/stage_sequencer.sv */
`timescale 1ns/1ps

module stage_sequencer
(
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  logic out_ready,
	input  logic gen_req_ready,
	input  logic calc_req_ready,
	input  logic comp_req_ready,
	input  logic gen_rsp_valid,
	input  logic calc_rsp_valid,
	input  logic comp_rsp_valid,
	output logic in_ready,
	output logic out_valid,
	output logic gen_req_valid,
	output logic calc_req_valid,
	output logic comp_req_valid,
	stage_if.seq st
);

	ctrl_pkg::stage_e stage;
	logic [1:0] slot;
	logic busy;
	logic engine;
	logic req_valid;
	logic req_ready;
	logic rsp_valid;

	// select the engine of the current stage
	always_comb
	begin
		engine    = 1'b1;
		req_ready = 1'b0;
		rsp_valid = 1'b0;
		case (stage)
			ctrl_pkg::ST_GENERATE:
			begin
				req_ready = gen_req_ready;
				rsp_valid = gen_rsp_valid;
			end
			ctrl_pkg::ST_CALCULATE:
			begin
				req_ready = calc_req_ready;
				rsp_valid = calc_rsp_valid;
			end
			ctrl_pkg::ST_COMPRESS:
			begin
				req_ready = comp_req_ready;
				rsp_valid = comp_rsp_valid;
			end
			default:
			begin
				engine = 1'b0;
			end
		endcase
	end

	// single issue, no new request until the response is back
	assign req_valid = engine && !busy;

	assign gen_req_valid  = req_valid && (stage == ctrl_pkg::ST_GENERATE);
	assign calc_req_valid = req_valid && (stage == ctrl_pkg::ST_CALCULATE);
	assign comp_req_valid = req_valid && (stage == ctrl_pkg::ST_COMPRESS);
	assign in_ready       = (stage == ctrl_pkg::ST_IDLE);
	assign out_valid      = (stage == ctrl_pkg::ST_DONE);

	assign st.stage   = stage;
	assign st.slot    = slot;
	assign st.issue   = req_valid && req_ready;
	assign st.capture = rsp_valid;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			busy <= 1'b0;
		else if (st.capture)
			busy <= 1'b0;
		else if (st.issue)
			busy <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			stage <= ctrl_pkg::ST_IDLE;
			slot  <= 2'd0;
		end
		else
		begin
			case (stage)
				ctrl_pkg::ST_IDLE:
				begin
					if (in_valid)
						stage <= ctrl_pkg::ST_GENERATE;
				end
				ctrl_pkg::ST_DONE:
				begin
					if (out_ready)
						stage <= ctrl_pkg::ST_IDLE;
				end
				default:
				begin
					// slot wraps to 0 together with the stage step
					if (st.capture)
					begin
						slot <= slot + 2'd1;
						if (slot == 2'd3)
							stage <= ctrl_pkg::stage_e'(stage + 3'd1);
					end
				end
			endcase
		end
	end

	a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid && !req_ready |=> req_valid && $stable(stage) && $stable(slot));

	a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({gen_req_valid, calc_req_valid, comp_req_valid}));

	// a response needs an accepted request of the same engine
	a_gen_rsp: assert property (@(posedge clk) disable iff (!rst_n)
		gen_rsp_valid |-> stage == ctrl_pkg::ST_GENERATE && (busy || st.issue));

	a_calc_rsp: assert property (@(posedge clk) disable iff (!rst_n)
		calc_rsp_valid |-> stage == ctrl_pkg::ST_CALCULATE && (busy || st.issue));

	a_comp_rsp: assert property (@(posedge clk) disable iff (!rst_n)
		comp_rsp_valid |-> stage == ctrl_pkg::ST_COMPRESS && (busy || st.issue));

endmodule

/* rtl/tile_buffer.sv */
`timescale 1ns/1ps
`include "tile_macros.svh"

module tile_buffer
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  logic                 in_ready,
	input  tile_pkg::tile_data_t in_b,
	input  tile_pkg::tile_data_t in_g,
	input  tile_pkg::tile_data_t in_r,
	input  tile_pkg::tile_data_t in_a,
	input  tile_pkg::orient_e    row_sel,
	input  tile_pkg::tile_data_t gen_row_abs,
	input  tile_pkg::tile_data_t gen_col_abs,
	input  tile_pkg::tile_flag_t gen_flag_row_abs,
	input  tile_pkg::tile_flag_t gen_flag_row,
	input  tile_pkg::tile_flag_t gen_flag_col,
	input  tile_pkg::tile_data_t comp_data,
	input  tile_pkg::comp_size_t comp_size,
	output tile_pkg::tile_data_t gen_data,
	output tile_pkg::tile_data_t comp_abs,
	output tile_pkg::tile_flag_t comp_flag,
	output tile_pkg::tile_flag_t flag_row [`NUM_CH],
	output tile_pkg::tile_flag_t flag_col [`NUM_CH],
	output tile_pkg::tile_data_t out_data [`NUM_CH],
	output tile_pkg::comp_size_t out_size [`NUM_CH],
	stage_if.unit st
);

	tile_pkg::tile_data_t tile [`NUM_CH];
	tile_pkg::tile_data_t row_abs [`NUM_CH];
	tile_pkg::tile_data_t col_abs [`NUM_CH];
	tile_pkg::tile_flag_t flag_row_abs [`NUM_CH];
	tile_pkg::channel_e ch;
	logic gen_done;
	logic comp_done;

	// slot counts channels in generate and compress
	assign ch        = tile_pkg::channel_e'(st.slot);
	assign gen_done  = st.capture && (st.stage == ctrl_pkg::ST_GENERATE);
	assign comp_done = st.capture && (st.stage == ctrl_pkg::ST_COMPRESS);

	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
		begin
			tile[tile_pkg::CH_B] <= in_b;
			tile[tile_pkg::CH_G] <= in_g;
			tile[tile_pkg::CH_R] <= in_r;
			tile[tile_pkg::CH_A] <= in_a;
		end
	end

	always_ff @(posedge clk)
	begin
		if (gen_done)
		begin
			row_abs[ch]      <= gen_row_abs;
			col_abs[ch]      <= gen_col_abs;
			flag_row_abs[ch] <= gen_flag_row_abs;
			flag_row[ch]     <= gen_flag_row;
			flag_col[ch]     <= gen_flag_col;
		end
	end

	always_ff @(posedge clk)
	begin
		if (comp_done)
			out_data[ch] <= comp_data;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			out_size <= '{default: '0};
		else if (comp_done)
			out_size[ch] <= comp_size;
	end

	assign gen_data = tile[ch];

	// row mode uses the data-abs flags, column mode the plain column flags
	assign comp_abs  = (row_sel == tile_pkg::ORIENT_ROW) ? row_abs[ch] : col_abs[ch];
	assign comp_flag = (row_sel == tile_pkg::ORIENT_ROW) ? flag_row_abs[ch] : flag_col[ch];

endmodule

/* rtl/orient_select.sv */
`timescale 1ns/1ps
`include "tile_macros.svh"

module orient_select
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  tile_pkg::tile_flag_t flag_row [`NUM_CH],
	input  tile_pkg::tile_flag_t flag_col [`NUM_CH],
	input  tile_pkg::calc_size_t calc_size,
	output tile_pkg::tile_flag_t calc_flag,
	output tile_pkg::orient_e    row_sel,
	stage_if.unit st
);

	tile_pkg::calc_size_t size [`NUM_CH];
	ctrl_pkg::calc_slot_e slot;
	logic [`CALC_SIZE_W:0] row_sum;
	logic [`CALC_SIZE_W:0] col_sum;

	assign slot = ctrl_pkg::calc_slot_e'(st.slot);

	// alpha first, then blue
	always_comb
	begin
		case (slot)
			ctrl_pkg::SLOT_A_ROW: calc_flag = flag_row[tile_pkg::CH_A];
			ctrl_pkg::SLOT_A_COL: calc_flag = flag_col[tile_pkg::CH_A];
			ctrl_pkg::SLOT_B_ROW: calc_flag = flag_row[tile_pkg::CH_B];
			default:              calc_flag = flag_col[tile_pkg::CH_B];
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			size <= '{default: '0};
		else if (st.capture && st.stage == ctrl_pkg::ST_CALCULATE)
			size[slot] <= calc_size;
	end

	assign row_sum = size[ctrl_pkg::SLOT_A_ROW] + size[ctrl_pkg::SLOT_B_ROW];
	assign col_sum = size[ctrl_pkg::SLOT_A_COL] + size[ctrl_pkg::SLOT_B_COL];

	// a tie keeps column
	assign row_sel = (row_sum < col_sum) ? tile_pkg::ORIENT_ROW : tile_pkg::ORIENT_COL;

endmodule

/* rtl/tile_compress_ctrl.sv */
`timescale 1ns/1ps
`include "tile_macros.svh"

module tile_compress_ctrl
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	output logic                 in_ready,
	input  tile_pkg::tile_data_t in_b,
	input  tile_pkg::tile_data_t in_g,
	input  tile_pkg::tile_data_t in_r,
	input  tile_pkg::tile_data_t in_a,
	output logic                 gen_req_valid,
	input  logic                 gen_req_ready,
	output tile_pkg::tile_data_t gen_data,
	input  logic                 gen_rsp_valid,
	input  tile_pkg::tile_data_t gen_row_abs,
	input  tile_pkg::tile_data_t gen_col_abs,
	input  tile_pkg::tile_flag_t gen_flag_row_abs,
	input  tile_pkg::tile_flag_t gen_flag_row,
	input  tile_pkg::tile_flag_t gen_flag_col,
	output logic                 calc_req_valid,
	input  logic                 calc_req_ready,
	output tile_pkg::tile_flag_t calc_flag,
	input  logic                 calc_rsp_valid,
	input  tile_pkg::calc_size_t calc_size,
	output logic                 comp_req_valid,
	input  logic                 comp_req_ready,
	output tile_pkg::tile_data_t comp_abs,
	output tile_pkg::tile_flag_t comp_flag,
	input  logic                 comp_rsp_valid,
	input  tile_pkg::tile_data_t comp_data,
	input  tile_pkg::comp_size_t comp_size,
	output logic                 out_valid,
	input  logic                 out_ready,
	output tile_pkg::orient_e    row_sel,
	output tile_pkg::tile_data_t out_b,
	output tile_pkg::tile_data_t out_g,
	output tile_pkg::tile_data_t out_r,
	output tile_pkg::tile_data_t out_a,
	output tile_pkg::comp_size_t out_b_size,
	output tile_pkg::comp_size_t out_g_size,
	output tile_pkg::comp_size_t out_r_size,
	output tile_pkg::comp_size_t out_a_size
);

	tile_pkg::tile_flag_t flag_row [`NUM_CH];
	tile_pkg::tile_flag_t flag_col [`NUM_CH];
	tile_pkg::tile_data_t out_data [`NUM_CH];
	tile_pkg::comp_size_t out_size [`NUM_CH];

	stage_if st_bus ();

	stage_sequencer i_seq
	(
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid       (in_valid),
		.out_ready      (out_ready),
		.gen_req_ready  (gen_req_ready),
		.calc_req_ready (calc_req_ready),
		.comp_req_ready (comp_req_ready),
		.gen_rsp_valid  (gen_rsp_valid),
		.calc_rsp_valid (calc_rsp_valid),
		.comp_rsp_valid (comp_rsp_valid),
		.in_ready       (in_ready),
		.out_valid      (out_valid),
		.gen_req_valid  (gen_req_valid),
		.calc_req_valid (calc_req_valid),
		.comp_req_valid (comp_req_valid),
		.st             (st_bus.seq)
	);

	tile_buffer i_buf
	(
		.clk              (clk),
		.rst_n            (rst_n),
		.in_valid         (in_valid),
		.in_ready         (in_ready),
		.in_b             (in_b),
		.in_g             (in_g),
		.in_r             (in_r),
		.in_a             (in_a),
		.row_sel          (row_sel),
		.gen_row_abs      (gen_row_abs),
		.gen_col_abs      (gen_col_abs),
		.gen_flag_row_abs (gen_flag_row_abs),
		.gen_flag_row     (gen_flag_row),
		.gen_flag_col     (gen_flag_col),
		.comp_data        (comp_data),
		.comp_size        (comp_size),
		.gen_data         (gen_data),
		.comp_abs         (comp_abs),
		.comp_flag        (comp_flag),
		.flag_row         (flag_row),
		.flag_col         (flag_col),
		.out_data         (out_data),
		.out_size         (out_size),
		.st               (st_bus.unit)
	);

	orient_select i_orient
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.flag_row  (flag_row),
		.flag_col  (flag_col),
		.calc_size (calc_size),
		.calc_flag (calc_flag),
		.row_sel   (row_sel),
		.st        (st_bus.unit)
	);

	assign out_b      = out_data[tile_pkg::CH_B];
	assign out_g      = out_data[tile_pkg::CH_G];
	assign out_r      = out_data[tile_pkg::CH_R];
	assign out_a      = out_data[tile_pkg::CH_A];
	assign out_b_size = out_size[tile_pkg::CH_B];
	assign out_g_size = out_size[tile_pkg::CH_G];
	assign out_r_size = out_size[tile_pkg::CH_R];
	assign out_a_size = out_size[tile_pkg::CH_A];

endmodule

/* sim/engine_models.sv */
`timescale 1ns/1ps

// one single-issue engine port with random ready and response latency
module engine_handshake
#(
	parameter int W    = 8,
	parameter int SEED = 0
)
(
	input  logic         clk,
	input  logic         rst_n,
	input  logic         req_valid,
	input  logic [W-1:0] payload,
	output logic         req_ready,
	output logic         rsp_valid,
	output logic [W-1:0] held,
	output int           errors
);

	integer seed;
	int delay;

	initial
	begin
		seed      = SEED;
		req_ready = 1'b0;
		rsp_valid = 1'b0;
		held      = '0;
		errors    = 0;
		forever
		begin
			@(posedge clk);
			#1;
			while (rst_n && req_valid)
			begin
				held  = payload;
				delay = $random(seed) & 7;
				repeat (delay)
				begin
					@(posedge clk);
					#1;
					if (!req_valid || payload !== held)
					begin
						$display("%m: request dropped or payload changed before ready at %0t",
							$time);
						errors++;
					end
				end
				req_ready = 1'b1;
				@(posedge clk);
				#1;
				req_ready = 1'b0;
				delay     = $random(seed) & 7;
				repeat (delay)
				begin
					@(posedge clk);
					#1;
				end
				// single-cycle response pulse
				rsp_valid = 1'b1;
				@(posedge clk);
				#1;
				rsp_valid = 1'b0;
			end
		end
	end

endmodule

module engine_models
#(
	parameter int SEED = 32'hf9f7
)
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 gen_req_valid,
	output logic                 gen_req_ready,
	input  tile_pkg::tile_data_t gen_data,
	output logic                 gen_rsp_valid,
	output tile_pkg::tile_data_t gen_row_abs,
	output tile_pkg::tile_data_t gen_col_abs,
	output tile_pkg::tile_flag_t gen_flag_row_abs,
	output tile_pkg::tile_flag_t gen_flag_row,
	output tile_pkg::tile_flag_t gen_flag_col,
	input  logic                 calc_req_valid,
	output logic                 calc_req_ready,
	input  tile_pkg::tile_flag_t calc_flag,
	output logic                 calc_rsp_valid,
	output tile_pkg::calc_size_t calc_size,
	input  logic                 comp_req_valid,
	output logic                 comp_req_ready,
	input  tile_pkg::tile_data_t comp_abs,
	input  tile_pkg::tile_flag_t comp_flag,
	output logic                 comp_rsp_valid,
	output tile_pkg::tile_data_t comp_data,
	output tile_pkg::comp_size_t comp_size,
	output int                   hold_errors
);

	tile_pkg::tile_data_t gen_held;
	tile_pkg::tile_flag_t calc_held;
	logic [703:0] comp_held;
	int gen_errors;
	int calc_errors;
	int comp_errors;

	engine_handshake #(.W(512), .SEED(SEED)) i_gen
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (gen_req_valid),
		.payload   (gen_data),
		.req_ready (gen_req_ready),
		.rsp_valid (gen_rsp_valid),
		.held      (gen_held),
		.errors    (gen_errors)
	);

	engine_handshake #(.W(192), .SEED(SEED + 1)) i_calc
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (calc_req_valid),
		.payload   (calc_flag),
		.req_ready (calc_req_ready),
		.rsp_valid (calc_rsp_valid),
		.held      (calc_held),
		.errors    (calc_errors)
	);

	engine_handshake #(.W(704), .SEED(SEED + 2)) i_comp
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (comp_req_valid),
		.payload   ({comp_abs, comp_flag}),
		.req_ready (comp_req_ready),
		.rsp_valid (comp_rsp_valid),
		.held      (comp_held),
		.errors    (comp_errors)
	);

	assign gen_row_abs      = gen_held ^ {64{8'h5a}};
	assign gen_col_abs      = {gen_held[503:0], gen_held[511:504]};
	assign gen_flag_row     = gen_held[191:0];
	assign gen_flag_col     = ~gen_held[191:0];
	assign gen_flag_row_abs = gen_held[191:0] ^ {24{8'h33}};

	// ones in the low 64 flag bits
	assign calc_size = tile_pkg::calc_size_t'($countones(calc_held[63:0]));

	assign comp_data = comp_held[703:192] ^ {320'b0, comp_held[191:0]};
	assign comp_size = comp_held[5:0];

	assign hold_errors = gen_errors + calc_errors + comp_errors;

endmodule

/* sim/tb_tile_compress_ctrl.sv */
`timescale 1ns/1ps
`include "tile_macros.svh"

module tb_tile_compress_ctrl
#(
	parameter int SEED = 32'hf9f7
);

	localparam int NUM_TILES      = 6;
	localparam int TIMEOUT_CYCLES = NUM_TILES * (12 * 16 + 40);

	typedef struct packed {
		logic [31:0]       pattern;
		int                stall;
		tile_pkg::orient_e orient;
	} tile_case_t;

	// one pattern byte per channel, blue in the low byte, alpha in the high byte
	// a and b high bits set the row, column or tie case
	tile_case_t cases [NUM_TILES] = '{
		'{32'h0c_a5_3c_03, 0, tile_pkg::ORIENT_ROW},
		'{32'hf8_96_69_ff, 3, tile_pkg::ORIENT_COL},
		'{32'h07_5a_e1_f8, 1, tile_pkg::ORIENT_COL},
		'{32'h21_c3_7e_18, 5, tile_pkg::ORIENT_ROW},
		'{32'h70_11_ee_88, 0, tile_pkg::ORIENT_COL},
		'{32'hfc_36_d2_c0, 2, tile_pkg::ORIENT_COL}
	};

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	logic out_valid;
	logic out_ready;
	logic gen_req_valid;
	logic gen_req_ready;
	logic gen_rsp_valid;
	logic calc_req_valid;
	logic calc_req_ready;
	logic calc_rsp_valid;
	logic comp_req_valid;
	logic comp_req_ready;
	logic comp_rsp_valid;
	tile_pkg::tile_data_t in_b;
	tile_pkg::tile_data_t in_g;
	tile_pkg::tile_data_t in_r;
	tile_pkg::tile_data_t in_a;
	tile_pkg::tile_data_t gen_data;
	tile_pkg::tile_data_t gen_row_abs;
	tile_pkg::tile_data_t gen_col_abs;
	tile_pkg::tile_flag_t gen_flag_row_abs;
	tile_pkg::tile_flag_t gen_flag_row;
	tile_pkg::tile_flag_t gen_flag_col;
	tile_pkg::tile_flag_t calc_flag;
	tile_pkg::calc_size_t calc_size;
	tile_pkg::tile_data_t comp_abs;
	tile_pkg::tile_flag_t comp_flag;
	tile_pkg::tile_data_t comp_data;
	tile_pkg::comp_size_t comp_size;
	tile_pkg::orient_e row_sel;
	tile_pkg::tile_data_t out_b;
	tile_pkg::tile_data_t out_g;
	tile_pkg::tile_data_t out_r;
	tile_pkg::tile_data_t out_a;
	tile_pkg::comp_size_t out_b_size;
	tile_pkg::comp_size_t out_g_size;
	tile_pkg::comp_size_t out_r_size;
	tile_pkg::comp_size_t out_a_size;
	int hold_errors;

	tile_pkg::tile_data_t ch_data [`NUM_CH];
	tile_pkg::tile_data_t exp_data [`NUM_CH];
	tile_pkg::comp_size_t exp_size [`NUM_CH];
	tile_pkg::orient_e exp_orient;
	int errors = 0;
	int cycles = 0;

	tile_compress_ctrl i_dut (.*);

	engine_models #(.SEED(SEED)) i_models (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// each byte depends on its index in the tile
	function automatic tile_pkg::tile_data_t fill_channel(input logic [7:0] p);
		tile_pkg::tile_data_t d;
		for (int k = 0; k < 64; k++)
			d[8*k +: 8] = p ^ 8'(k);
		return d;
	endfunction

	function automatic tile_pkg::orient_e orient_rule(input tile_pkg::tile_data_t a,
		input tile_pkg::tile_data_t b);
		int row_sum;
		int col_sum;
		row_sum = $countones(a[63:0]) + $countones(b[63:0]);
		col_sum = $countones(~a[63:0]) + $countones(~b[63:0]);
		return (row_sum < col_sum) ? tile_pkg::ORIENT_ROW : tile_pkg::ORIENT_COL;
	endfunction

	function automatic tile_pkg::tile_flag_t flag_for(input tile_pkg::tile_data_t d,
		input tile_pkg::orient_e o);
		return (o == tile_pkg::ORIENT_ROW) ? d[191:0] ^ {24{8'h33}} : ~d[191:0];
	endfunction

	function automatic tile_pkg::tile_data_t abs_for(input tile_pkg::tile_data_t d,
		input tile_pkg::orient_e o);
		return (o == tile_pkg::ORIENT_ROW) ? d ^ {64{8'h5a}} : {d[503:0], d[511:504]};
	endfunction

	task expect_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
			errors++;
		end
	endtask

	task verify_bus(input string name, input tile_pkg::tile_data_t got,
		input tile_pkg::tile_data_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task check_size(input string name, input tile_pkg::comp_size_t got,
		input tile_pkg::comp_size_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got);
			errors++;
		end
	endtask

	task check_outputs;
		if (row_sel !== exp_orient)
		begin
			$display("Mismatch at %0t: row_sel expected %0d got %0d", $time, exp_orient, row_sel);
			errors++;
		end
		verify_bus("out_b", out_b, exp_data[tile_pkg::CH_B]);
		verify_bus("out_g", out_g, exp_data[tile_pkg::CH_G]);
		verify_bus("out_r", out_r, exp_data[tile_pkg::CH_R]);
		verify_bus("out_a", out_a, exp_data[tile_pkg::CH_A]);
		check_size("out_b_size", out_b_size, exp_size[tile_pkg::CH_B]);
		check_size("out_g_size", out_g_size, exp_size[tile_pkg::CH_G]);
		check_size("out_r_size", out_r_size, exp_size[tile_pkg::CH_R]);
		check_size("out_a_size", out_a_size, exp_size[tile_pkg::CH_A]);
	endtask

	initial
	begin
		tile_pkg::tile_flag_t flag;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		out_ready = 1'b0;
		in_b      = '0;
		in_g      = '0;
		in_r      = '0;
		in_a      = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		expect_bit("in_ready", in_ready, 1'b1);
		expect_bit("out_valid", out_valid, 1'b0);
		expect_bit("gen_req_valid", gen_req_valid, 1'b0);
		expect_bit("calc_req_valid", calc_req_valid, 1'b0);
		expect_bit("comp_req_valid", comp_req_valid, 1'b0);

		for (int i = 0; i < NUM_TILES; i++)
		begin
			for (int c = 0; c < `NUM_CH; c++)
				ch_data[c] = fill_channel(cases[i].pattern[8*c +: 8]);
			exp_orient = cases[i].orient;
			if (orient_rule(ch_data[tile_pkg::CH_A], ch_data[tile_pkg::CH_B]) != exp_orient)
			begin
				$display("table entry %0d does not follow the orientation rule", i);
				errors++;
			end
			for (int c = 0; c < `NUM_CH; c++)
			begin
				flag        = flag_for(ch_data[c], exp_orient);
				exp_data[c] = abs_for(ch_data[c], exp_orient) ^ {320'b0, flag};
				exp_size[c] = flag[5:0];
			end

			in_b     = ch_data[tile_pkg::CH_B];
			in_g     = ch_data[tile_pkg::CH_G];
			in_r     = ch_data[tile_pkg::CH_R];
			in_a     = ch_data[tile_pkg::CH_A];
			in_valid = 1'b1;
			@(posedge clk);
			#1;
			in_valid = 1'b0;

			while (!out_valid)
			begin
				if (in_ready)
				begin
					$display("in_ready went high at %0t while tile %0d was in process", $time, i);
					errors++;
				end
				@(posedge clk);
				#1;
			end
			check_outputs();

			// result must hold while out_ready is low
			for (int s = 0; s < cases[i].stall; s++)
			begin
				@(posedge clk);
				#1;
				if (!out_valid || in_ready)
				begin
					$display("result of tile %0d not held during the stall at %0t", i, $time);
					errors++;
				end
				check_outputs();
			end

			out_ready = 1'b1;
			@(posedge clk);
			#1;
			out_ready = 1'b0;
			if (out_valid || !in_ready)
			begin
				$display("controller did not return to idle after tile %0d at %0t", i, $time);
				errors++;
			end
		end

		$display("errors: %0d output checks, %0d request hold checks", errors, hold_errors);
		if (errors == 0 && hold_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+rtl
rtl/tile_pkg.sv
rtl/ctrl_pkg.sv
rtl/stage_if.sv
rtl/stage_sequencer.sv
rtl/tile_buffer.sv
rtl/orient_select.sv
rtl/tile_compress_ctrl.sv
sim/engine_models.sv
sim/tb_tile_compress_ctrl.sv

/* Makefile */
# Verilator build and run for the tile compression controller

TOP       ?= tb_tile_compress_ctrl
SEED      ?= 63991
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f verilog.f --top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
